//--- verilog/mem_1rw_params.svh
`ifndef MEM_1RW_PARAMS_SVH
`define MEM_1RW_PARAMS_SVH

// logical side
`define MEM_WIDTH       16
`define MEM_NUMVBNK     4
`define MEM_BITVBNK     2
`define MEM_BITVROW     6
`define MEM_BITADDR     (`MEM_BITVBNK + `MEM_BITVROW)

// physical macro geometry
`define MEM_NUMWRDS     4
`define MEM_BITWRDS     2
`define MEM_NUMSROW     16
`define MEM_BITSROW     4
`define MEM_PHYWDTH     (`MEM_NUMWRDS * `MEM_WIDTH)
`define MEM_SRAM_DELAY  2

// refresh sub-banks are the top bits of the physical row
`define MEM_NUMRBNK     4
`define MEM_BITRBNK     2

`define MEM_BITPADR     (`MEM_BITVBNK + `MEM_BITSROW + `MEM_BITWRDS)

`endif

//--- verilog/mem_1rw_pkg.sv
`default_nettype none
`include "mem_1rw_params.svh"

package mem_1rw_pkg;

  // logical request for one bank
  typedef struct packed {
    logic                    read;
    logic                    write;
    logic [`MEM_BITVROW-1:0] vrow;
    logic [`MEM_WIDTH-1:0]   din;
  } bank_cmd_t;

  // one physical row seen flat or as word slots
  typedef union packed {
    logic [`MEM_PHYWDTH-1:0]                  flat;
    logic [`MEM_NUMWRDS-1:0][`MEM_WIDTH-1:0] word;
  } phys_row_u;

  typedef struct packed {
    logic                    read;
    logic                    write;
    logic [`MEM_BITSROW-1:0] addr;
    phys_row_u               bw;
    phys_row_u               din;
  } phys_port_t;

  typedef struct packed {
    logic                    refr;
    logic [`MEM_BITRBNK-1:0] bank;
  } refr_port_t;

endpackage

`default_nettype wire

//--- verilog/bank_router.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module bank_router (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    read,
  input  logic                                    write,
  input  logic [`MEM_BITADDR-1:0]                 addr,
  input  logic [`MEM_WIDTH-1:0]                   din,
  input  logic [`MEM_NUMVBNK-1:0][`MEM_WIDTH-1:0] word_dout,
  output logic                                    ready,
  output mem_1rw_pkg::bank_cmd_t [`MEM_NUMVBNK-1:0] bank_cmd,
  output logic                                    clr_active,
  output logic [`MEM_BITSROW-1:0]                 clr_row,
  output logic                                    rd_vld,
  output logic [`MEM_WIDTH-1:0]                   rd_dout,
  output logic [`MEM_BITPADR-1:0]                 rd_padr
);

  typedef struct packed {
    logic [`MEM_BITVBNK-1:0] bank;
    logic [`MEM_BITPADR-1:0] padr;
  } rd_tag_t;

  logic [`MEM_BITVBNK-1:0]    bank;
  logic [`MEM_BITVROW-1:0]    vrow;
  logic                       rd_acc;
  rd_tag_t                    rd_tag;
  logic [`MEM_SRAM_DELAY-1:0] vld_pipe;
  rd_tag_t [`MEM_SRAM_DELAY-1:0] tag_pipe;

  assign bank   = addr[`MEM_BITADDR-1 -: `MEM_BITVBNK];
  assign vrow   = addr[`MEM_BITVROW-1:0];
  assign rd_acc = ready && read;

  // bank, physical row, word slot
  assign rd_tag.bank = bank;
  assign rd_tag.padr = {bank, vrow[`MEM_BITVROW-1 -: `MEM_BITSROW], vrow[`MEM_BITWRDS-1:0]};

  // only the addressed bank sees the strobe
  always_comb begin
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      bank_cmd[b].read  = rd_acc && (bank == `MEM_BITVBNK'(b));
      bank_cmd[b].write = ready && write && (bank == `MEM_BITVBNK'(b));
      bank_cmd[b].vrow  = vrow;
      bank_cmd[b].din   = din;
    end
  end

  // clear sweep over all physical rows before ready rises
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clr_active <= 1'b0;
      clr_row    <= '0;
      ready      <= 1'b0;
    end else if (!ready && !clr_active) begin
      clr_active <= 1'b1;
    end else if (clr_active) begin
      if (clr_row == `MEM_BITSROW'(`MEM_NUMSROW - 1)) begin
        clr_active <= 1'b0;
        ready      <= 1'b1;
      end
      clr_row <= clr_row + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_pipe <= '0;
      rd_vld   <= 1'b0;
    end else begin
      vld_pipe[0] <= rd_acc;
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
      rd_vld <= vld_pipe[`MEM_SRAM_DELAY-1];
    end
  end

  // tags follow the macro latency
  always_ff @(posedge clk) begin
    tag_pipe[0] <= rd_tag;
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
    end
    rd_dout <= word_dout[tag_pipe[`MEM_SRAM_DELAY-1].bank];
    rd_padr <= tag_pipe[`MEM_SRAM_DELAY-1].padr;
  end

endmodule

`default_nettype wire

//--- verilog/row_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module row_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  mem_1rw_pkg::bank_cmd_t     cmd,
  input  logic                       clr_active,
  input  logic [`MEM_BITSROW-1:0]    clr_row,
  output mem_1rw_pkg::phys_port_t    phys_cmd,
  input  mem_1rw_pkg::phys_row_u     phys_dout,
  output logic [`MEM_WIDTH-1:0]      word_dout
);

  logic [`MEM_BITSROW-1:0] prow;
  logic [`MEM_BITWRDS-1:0] slot;
  logic [`MEM_SRAM_DELAY-1:0][`MEM_BITWRDS-1:0] slot_pipe;

  // upper bits pick the row and lower bits the word in it
  assign prow = cmd.vrow[`MEM_BITVROW-1 -: `MEM_BITSROW];
  assign slot = cmd.vrow[`MEM_BITWRDS-1:0];

  always_comb begin
    phys_cmd = '0;
    if (clr_active) begin
      // full-mask zero row
      phys_cmd.write    = 1'b1;
      phys_cmd.addr     = clr_row;
      phys_cmd.bw.flat  = '1;
      phys_cmd.din.flat = '0;
    end else begin
      phys_cmd.read     = cmd.read;
      phys_cmd.write    = cmd.write;
      phys_cmd.addr     = prow;
      phys_cmd.din.flat = {`MEM_NUMWRDS{cmd.din}};
      if (cmd.write) begin
        phys_cmd.bw.word[slot] = '1;
      end
    end
  end

  // slot index travels alongside the macro read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_pipe <= '0;
    end else begin
      slot_pipe[0] <= slot;
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        slot_pipe[i] <= slot_pipe[i-1];
      end
    end
  end

  assign word_dout = phys_dout.word[slot_pipe[`MEM_SRAM_DELAY-1]];

endmodule

`default_nettype wire

//--- verilog/refresh_sched.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module refresh_sched (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    refr,
  input  mem_1rw_pkg::phys_port_t acc_cmd,
  output mem_1rw_pkg::refr_port_t refr_cmd
);

  logic [`MEM_BITRBNK-1:0] ptr;
  logic                    pending;
  logic [`MEM_BITRBNK-1:0] acc_rbnk;
  logic                    conflict;
  logic                    issue;

  // sub-bank of the current access
  assign acc_rbnk = acc_cmd.addr[`MEM_BITSROW-1 -: `MEM_BITRBNK];
  assign conflict = (acc_cmd.read || acc_cmd.write) && (acc_rbnk == ptr);
  assign issue    = pending && !conflict;

  assign refr_cmd.refr = issue;
  assign refr_cmd.bank = ptr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr     <= '0;
      pending <= 1'b0;
    end else begin
      // a new pulse during issue keeps the request alive
      pending <= refr || (pending && !issue);
      if (issue) begin
        ptr <= ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_1rw_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module mem_1rw_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         refr,
  input  logic                                         read,
  input  logic                                         write,
  input  logic [`MEM_BITADDR-1:0]                      addr,
  input  logic [`MEM_WIDTH-1:0]                        din,
  output logic                                         ready,
  output logic                                         rd_vld,
  output logic [`MEM_WIDTH-1:0]                        rd_dout,
  output logic [`MEM_BITPADR-1:0]                      rd_padr,
  output mem_1rw_pkg::phys_port_t [`MEM_NUMVBNK-1:0]   phys_cmd,
  input  mem_1rw_pkg::phys_row_u [`MEM_NUMVBNK-1:0]    phys_dout,
  output mem_1rw_pkg::refr_port_t [`MEM_NUMVBNK-1:0]   refr_cmd
);

  mem_1rw_pkg::bank_cmd_t [`MEM_NUMVBNK-1:0]   bank_cmd;
  logic [`MEM_NUMVBNK-1:0][`MEM_WIDTH-1:0]     word_dout;
  logic                                        clr_active;
  logic [`MEM_BITSROW-1:0]                     clr_row;

  bank_router router_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .read       (read),
    .write      (write),
    .addr       (addr),
    .din        (din),
    .word_dout  (word_dout),
    .ready      (ready),
    .bank_cmd   (bank_cmd),
    .clr_active (clr_active),
    .clr_row    (clr_row),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout),
    .rd_padr    (rd_padr)
  );

  // one aligner and one refresh scheduler per macro
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    row_align align_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd        (bank_cmd[b]),
      .clr_active (clr_active),
      .clr_row    (clr_row),
      .phys_cmd   (phys_cmd[b]),
      .phys_dout  (phys_dout[b]),
      .word_dout  (word_dout[b])
    );

    refresh_sched refr_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .refr     (refr),
      .acc_cmd  (phys_cmd[b]),
      .refr_cmd (refr_cmd[b])
    );
  end

endmodule

`default_nettype wire

//--- tests/sram_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module sram_model (
  input  logic                                       clk,
  input  mem_1rw_pkg::phys_port_t [`MEM_NUMVBNK-1:0] phys_cmd,
  output mem_1rw_pkg::phys_row_u [`MEM_NUMVBNK-1:0]  phys_dout
);

  mem_1rw_pkg::phys_row_u mem [`MEM_NUMVBNK][`MEM_NUMSROW];
  mem_1rw_pkg::phys_row_u dly [`MEM_NUMVBNK][`MEM_SRAM_DELAY];

  // power-up garbage that differs in every row of every macro
  initial begin
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      for (int r = 0; r < `MEM_NUMSROW; r++) begin
        mem[b][r].flat = {`MEM_NUMWRDS{16'hc3a5 ^ 16'(b * `MEM_NUMSROW + r)}};
      end
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      if (phys_cmd[b].write) begin
        mem[b][phys_cmd[b].addr].flat <=
          (mem[b][phys_cmd[b].addr].flat & ~phys_cmd[b].bw.flat) |
          (phys_cmd[b].din.flat & phys_cmd[b].bw.flat);
      end
      if (phys_cmd[b].read) begin
        dly[b][0] <= mem[b][phys_cmd[b].addr];
      end
      // fixed read latency
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        dly[b][i] <= dly[b][i-1];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      phys_dout[b] = dly[b][`MEM_SRAM_DELAY-1];
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_mem_1rw.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_1rw_params.svh"

module tb_mem_1rw;

  localparam int CLK_PERIOD    = 100;
  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 10;
  localparam int READ_LATENCY  = 3;

  typedef struct packed {
    int unsigned             due;
    logic [`MEM_WIDTH-1:0]   data;
    logic [`MEM_BITPADR-1:0] padr;
  } exp_read_t;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       refr;
  logic                                       read;
  logic                                       write;
  logic [`MEM_BITADDR-1:0]                    addr;
  logic [`MEM_WIDTH-1:0]                      din;
  logic                                       ready;
  logic                                       rd_vld;
  logic [`MEM_WIDTH-1:0]                      rd_dout;
  logic [`MEM_BITPADR-1:0]                    rd_padr;
  mem_1rw_pkg::phys_port_t [`MEM_NUMVBNK-1:0] phys_cmd;
  mem_1rw_pkg::phys_row_u [`MEM_NUMVBNK-1:0]  phys_dout;
  mem_1rw_pkg::refr_port_t [`MEM_NUMVBNK-1:0] refr_cmd;

  // reference model state
  logic [`MEM_WIDTH-1:0]   exp_mem [2**`MEM_BITADDR];
  exp_read_t               rd_q [$];
  logic [`MEM_BITRBNK-1:0] refr_ptr [`MEM_NUMVBNK];
  logic                    refr_pend [`MEM_NUMVBNK];
  logic                    exp_ready;
  logic [31:0]             rng;
  int unsigned             cycle;
  int unsigned             checks;
  int unsigned             errors;
  int unsigned             timeouts;

  mem_1rw_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .refr      (refr),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .ready     (ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr),
    .phys_cmd  (phys_cmd),
    .phys_dout (phys_dout),
    .refr_cmd  (refr_cmd)
  );

  sram_model sram_i (
    .clk       (clk),
    .phys_cmd  (phys_cmd),
    .phys_dout (phys_dout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // registered read outputs sampled on the falling edge
  task automatic check_read_return();
    if (rd_q.size() > 0 && rd_q[0].due == cycle) begin
      compare_values("rd_vld", 32'(rd_vld), 32'd1);
      compare_values("rd_dout", 32'(rd_dout), 32'(rd_q[0].data));
      compare_values("rd_padr", 32'(rd_padr), 32'(rd_q[0].padr));
      void'(rd_q.pop_front());
    end else begin
      compare_values("rd_vld", 32'(rd_vld), 32'd0);
    end
  endtask

  task automatic check_refresh(input logic acc, input logic [`MEM_BITADDR-1:0] a,
                               input logic rf);
    logic conflict;
    logic exp_issue;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      conflict  = acc && (a[`MEM_BITADDR-1 -: `MEM_BITVBNK] == `MEM_BITVBNK'(b)) &&
                  (a[`MEM_BITVROW-1 -: `MEM_BITRBNK] == refr_ptr[b]);
      exp_issue = refr_pend[b] && !conflict;
      compare_values($sformatf("refr_cmd[%0d].refr", b), 32'(refr_cmd[b].refr),
                     32'(exp_issue));
      if (exp_issue) begin
        compare_values($sformatf("refr_cmd[%0d].bank", b), 32'(refr_cmd[b].bank),
                       32'(refr_ptr[b]));
        refr_ptr[b] = refr_ptr[b] + 1'b1;
      end
      refr_pend[b] = rf || (refr_pend[b] && !exp_issue);
    end
  endtask

  // drive on the falling edge and check refresh mid-cycle
  task automatic run_cycle(input logic rd, input logic wr,
                           input logic [`MEM_BITADDR-1:0] a,
                           input logic [`MEM_WIDTH-1:0] d, input logic rf);
    logic      acc;
    exp_read_t er;
    @(negedge clk);
    cycle++;
    check_read_return();
    if (exp_ready) begin
      compare_values("ready", 32'(ready), 32'd1);
    end
    read  = rd;
    write = wr;
    addr  = a;
    din   = d;
    refr  = rf;
    acc   = exp_ready && (rd || wr);
    if (exp_ready && wr) begin
      exp_mem[a] = d;
    end
    if (exp_ready && rd) begin
      er.due  = cycle + READ_LATENCY;
      er.data = exp_mem[a];
      er.padr = {a[`MEM_BITADDR-1 -: `MEM_BITVBNK], a[`MEM_BITVROW-1 -: `MEM_BITSROW],
                 a[`MEM_BITWRDS-1:0]};
      rd_q.push_back(er);
    end
    #(CLK_PERIOD / 4);
    check_refresh(acc, a, rf);
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
  endtask

  initial begin
    logic [31:0]             r;
    logic [`MEM_BITRBNK-1:0] saved_ptr;
    logic [`MEM_BITADDR-1:0] caddr;
    rng       = 32'd16;
    cycle     = 0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    exp_ready = 1'b0;
    rst_n     = 1'b0;
    refr      = 1'b0;
    read      = 1'b0;
    write     = 1'b0;
    addr      = '0;
    din       = '0;
    for (int i = 0; i < 2**`MEM_BITADDR; i++) begin
      exp_mem[i] = '0;
    end
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      refr_ptr[b]  = '0;
      refr_pend[b] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < READY_TIMEOUT && !ready; i++) begin
      idle_cycle();
    end
    if (!ready) begin
      timeouts++;
      $display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
    end else begin
      // ready is a level and stays high from here on
      exp_ready = 1'b1;

      // every word reads zero after the clear sweep
      for (int i = 0; i < 2**`MEM_BITADDR; i++) begin
        run_cycle(1'b1, 1'b0, `MEM_BITADDR'(i), '0, 1'b0);
      end

      // fill one physical row word by word and rewrite one word
      for (int w = 0; w < `MEM_NUMWRDS; w++) begin
        r = next_random();
        run_cycle(1'b0, 1'b1, {2'd2, 4'd9, 2'(w)}, r[15:0], 1'b0);
      end
      run_cycle(1'b0, 1'b1, {2'd2, 4'd9, 2'd2}, 16'h5a5a, 1'b0);
      for (int w = 0; w < `MEM_NUMWRDS; w++) begin
        run_cycle(1'b1, 1'b0, {2'd2, 4'd9, 2'(w)}, '0, 1'b0);
      end

      // pointer walk 0,1,2,3,0 with no access
      for (int i = 0; i < 5; i++) begin
        run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
        idle_cycle();
        for (int b = 0; b < `MEM_NUMVBNK; b++) begin
          compare_values("refresh issued after pulse", 32'(refr_cmd[b].refr), 32'd1);
          compare_values("refresh sub-bank", 32'(refr_cmd[b].bank), 32'(i % 4));
        end
        idle_cycle();
      end

      // bank 0 access hits its pointer sub-bank and delays the refresh
      saved_ptr = refr_ptr[0];
      caddr     = {2'd0, saved_ptr, 4'd0};
      run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
      run_cycle(1'b1, 1'b0, caddr, '0, 1'b0);
      compare_values("bank 0 refresh deferred", 32'(refr_cmd[0].refr), 32'd0);
      compare_values("bank 1 refresh on time", 32'(refr_cmd[1].refr), 32'd1);
      idle_cycle();
      compare_values("bank 0 deferred refresh", 32'(refr_cmd[0].refr), 32'd1);
      compare_values("bank 0 deferred sub-bank", 32'(refr_cmd[0].bank), 32'(saved_ptr));

      for (int i = 0; i < 600; i++) begin
        r = next_random();
        run_cycle(r[1:0] == 2'd3, r[1:0] == 2'd1 || r[1:0] == 2'd2, r[15:8], r[31:16],
                  r[4:2] == 3'd0);
      end

      for (int i = 0; i < DRAIN_TIMEOUT && rd_q.size() > 0; i++) begin
        idle_cycle();
      end
      if (rd_q.size() > 0) begin
        timeouts++;
        $display("%0d reads never returned within %0d cycles", rd_q.size(), DRAIN_TIMEOUT);
      end
    end

    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/mem_1rw_pkg.sv
verilog/bank_router.sv
verilog/row_align.sv
verilog/refresh_sched.sv
verilog/mem_1rw_top.sv
tests/sram_model.sv
tests/tb_mem_1rw.sv

//--- Bender.yml
package:
  name: mem_1rw

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_1rw_pkg.sv
      - verilog/bank_router.sv
      - verilog/row_align.sv
      - verilog/refresh_sched.sv
      - verilog/mem_1rw_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tests/sram_model.sv
      - tests/tb_mem_1rw.sv
